// File: verilog.f
+incdir+src
src/exu_pkg.sv
src/exu_alu.sv
src/exu_mem_align.sv
src/exu_branch.sv
src/exu.sv
src/data_ram.sv
src/exu_top.sv
sim/exu_properties.sv
sim/tb_exu_top.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_exu_top &&
./obj_dir/Vtb_exu_top | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/tb_exu_top.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module tb_exu_top;
  import exu_pkg::*;

  localparam int wait_limit = 50;
  localparam int ram_bytes  = `EXU_RAM_WORDS * 8;

  logic                   clock;
  logic                   reset;
  logic                   in_valid;
  logic                   in_ready;
  logic [`EXU_XLEN-1:0]   in_pc;
  logic [`EXU_XLEN-1:0]   in_val_a;
  logic [`EXU_XLEN-1:0]   in_val_b;
  logic [`EXU_XLEN-1:0]   in_val_c;
  logic                   in_alu_src;
  alu_funct_t             in_alu_funct;
  logic                   in_alu_sw;
  logic [4:0]             in_rd;
  logic                   in_rd_src;
  logic [3:0]             in_ls;
  goto_t                  in_goto;
  logic [1:0]             in_csrw;
  logic                   out_ready;
  logic                   out_valid;
  logic                   out_gpr_wen;
  logic [4:0]             out_gpr_waddr;
  logic [`EXU_XLEN-1:0]   out_gpr_wdata;
  logic                   out_csr_wen;
  logic [`EXU_CSR_AW-1:0] out_csr_waddr;
  logic [`EXU_XLEN-1:0]   out_csr_wdata;
  logic                   jump_flush;
  logic [`EXU_XLEN-1:0]   jump_dnpc;
  logic [4:0]             fwd_rd;
  logic [`EXU_XLEN-1:0]   fwd_gpr_wdata;
  logic [`EXU_CSR_AW-1:0] fwd_csr_waddr;

  integer     seed;
  string      test_name;
  logic [7:0] shadow [ram_bytes];

  // expected writeback of the instruction in flight
  logic                   exp_gpr_wen;
  logic [4:0]             exp_rd;
  logic [`EXU_XLEN-1:0]   exp_gpr_wdata;
  logic                   exp_csr_wen;
  logic [`EXU_CSR_AW-1:0] exp_csr_waddr;
  logic [`EXU_XLEN-1:0]   exp_csr_wdata;
  logic                   exp_flush;
  logic [`EXU_XLEN-1:0]   exp_dnpc;

  exu_top dut_i (.*);

  always #20 clock = ~clock;

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
    else fail_run($sformatf("ERR %s %s expected %h actual %h",
                            test_name, what, expected, actual));
  endtask

  function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b,
                                          alu_funct_t f, logic sw);
    logic [4:0] sh;
    sh = b[4:0];
    case (f)
      alu_add:  alu_ref = sw ? a - b : a + b;
      alu_sll:  alu_ref = a << sh;
      alu_slt:  alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: alu_ref = (a < b) ? 32'd1 : 32'd0;
      alu_xor:  alu_ref = a ^ b;
      alu_srl: begin
        // arithmetic shift as the complement of a logical one
        if (sw && a[31]) begin
          alu_ref = ~(~a >> sh);
        end else begin
          alu_ref = a >> sh;
        end
      end
      alu_or:   alu_ref = a | b;
      default:  alu_ref = a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(logic [31:0] addr, logic [3:0] ls);
    logic [31:0] raw;
    int          n;
    n = 1 << ls[1:0];
    raw = '0;
    for (int i = 0; i < n; i++) begin
      raw[i*8 +: 8] = shadow[addr + i];
    end
    if (n == 1 && ls[2] && raw[7]) raw[31:8] = '1;
    if (n == 2 && ls[2] && raw[15]) raw[31:16] = '1;
    return raw;
  endfunction

  task automatic store_ref(logic [31:0] addr, logic [1:0] size, logic [31:0] value);
    for (int i = 0; i < (1 << size); i++) begin
      shadow[addr + i] = value[i*8 +: 8];
    end
  endtask

  task automatic clear_instr();
    in_pc        = 32'h8000_0000;
    in_val_a     = '0;
    in_val_b     = '0;
    in_val_c     = '0;
    in_alu_src   = 1'b0;
    in_alu_funct = alu_add;
    in_alu_sw    = 1'b0;
    in_rd        = '0;
    in_rd_src    = 1'b0;
    in_ls        = '0;
    in_goto      = goto_none;
    in_csrw      = '0;
  endtask

  task automatic compute_expected();
    logic [31:0] alu_out;
    logic        taken;
    logic        predicted;
    alu_out = alu_ref(in_alu_src ? in_pc : in_val_a, in_val_b, in_alu_funct, in_alu_sw);
    exp_rd      = in_rd;
    exp_gpr_wen = (in_rd != 5'd0);
    if (in_ls[3]) begin
      exp_gpr_wdata = load_ref(alu_out, in_ls);
    end else if (in_rd_src) begin
      exp_gpr_wdata = in_val_a;
    end else begin
      exp_gpr_wdata = alu_out;
    end
    exp_csr_wen   = (in_csrw != 2'd0);
    exp_csr_waddr = (in_csrw == 2'd3) ? '0 : in_val_c[`EXU_CSR_AW-1:0];
    exp_csr_wdata = (in_csrw == 2'd1) ? alu_out : in_val_b;
    case (in_goto)
      goto_none:      taken = 1'b0;
      goto_branch_nz: taken = (alu_out != 32'd0);
      goto_branch_z:  taken = (alu_out == 32'd0);
      default:        taken = 1'b1;
    endcase
    if (!taken) begin
      exp_dnpc = in_pc + 32'd4;
    end else if (in_goto == goto_jalr) begin
      exp_dnpc = in_val_a + in_val_c;
    end else if (in_goto == goto_jump_reg) begin
      exp_dnpc = in_val_a;
    end else begin
      exp_dnpc = in_pc + in_val_c;
    end
    exp_dnpc[0] = 1'b0;
    // backward branches predicted taken
    predicted = (in_goto == goto_branch_nz || in_goto == goto_branch_z) && in_val_c[31];
    exp_flush = taken ^ predicted;
  endtask

  task automatic check_outputs();
    check_value("out_valid", 1, out_valid);
    check_value("gpr_wen", exp_gpr_wen, out_gpr_wen);
    check_value("gpr_waddr", exp_rd, out_gpr_waddr);
    check_value("gpr_wdata", exp_gpr_wdata, out_gpr_wdata);
    check_value("fwd_rd", exp_rd, fwd_rd);
    check_value("fwd_gpr_wdata", exp_gpr_wdata, fwd_gpr_wdata);
    check_value("csr_wen", exp_csr_wen, out_csr_wen);
    if (exp_csr_wen) begin
      check_value("csr_waddr", exp_csr_waddr, out_csr_waddr);
      check_value("csr_wdata", exp_csr_wdata, out_csr_wdata);
      check_value("fwd_csr_waddr", exp_csr_waddr, fwd_csr_waddr);
    end
    check_value("jump_flush", exp_flush, jump_flush);
    check_value("jump_dnpc", exp_dnpc, jump_dnpc);
  endtask

  // called #2 after an edge, returns #2 after the accepting edge
  task automatic send_instr();
    int cycles;
    cycles = 0;
    in_valid = 1'b1;
    @(negedge clock);
    while (!in_ready) begin
      cycles++;
      if (cycles > wait_limit) fail_run("in_ready never came high");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic collect_result();
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      out_ready = 1'($random(seed));
      @(negedge clock);
      if (out_valid && out_ready) begin
        check_outputs();
        done = 1'b1;
      end else begin
        cycles++;
        if (cycles > wait_limit) fail_run("no result handshake on out_valid");
      end
      @(posedge clock);
      #2;
    end
    out_ready = 1'b0;
  endtask

  task automatic wait_hold();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!out_valid) begin
      cycles++;
      if (cycles > wait_limit) fail_run("out_valid never came high while stalled");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
  endtask

  always @(negedge clock) begin
    if (dut_i.props_i.fail_count != 0) fail_run("a protocol property of the DUT failed");
  end

  initial begin
    logic [31:0] region;
    logic [31:0] offset;
    logic [31:0] rnd;
    logic [1:0]  size;
    seed      = 32'hdc69_1855;
    clock     = 1'b0;
    reset     = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    test_name = "reset";
    clear_instr();
    for (int i = 0; i < ram_bytes; i++) begin
      shadow[i] = 8'h00;
    end
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;

    test_name = "alu";
    for (int i = 0; i < 40; i++) begin
      clear_instr();
      in_pc        = 32'h8000_0000 | (32'($random(seed)) & 32'h0000_fffc);
      in_val_a     = $random(seed);
      in_val_b     = $random(seed);
      in_alu_funct = alu_funct_t'(i[2:0]);
      in_alu_sw    = 1'($random(seed));
      in_alu_src   = 1'($random(seed));
      in_rd_src    = 1'($random(seed));
      in_rd        = (i % 5 == 0) ? 5'd0 : 5'($random(seed));
      compute_expected();
      send_instr();
      collect_result();
    end

    test_name = "store";
    region = 32'($random(seed)) & 32'h0000_07c0;
    for (int i = 0; i < 24; i++) begin
      clear_instr();
      rnd    = $random(seed);
      size   = (rnd[1:0] == 2'd3) ? 2'd2 : rnd[1:0];
      offset = 32'($random(seed)) & 32'h3f;
      offset = offset & ~((32'd1 << size) - 32'd1);
      in_val_a = region;
      in_val_b = offset;
      in_val_c = $random(seed);
      in_ls    = {2'b01, size};
      compute_expected();
      store_ref(region + offset, size, in_val_c);
      send_instr();
      collect_result();
    end

    test_name = "load";
    for (int i = 0; i < 30; i++) begin
      clear_instr();
      case (i % 5)
        0:       in_ls = 4'b1100;
        1:       in_ls = 4'b1000;
        2:       in_ls = 4'b1101;
        3:       in_ls = 4'b1001;
        default: in_ls = 4'b1110;
      endcase
      offset = 32'($random(seed)) & 32'h3f;
      offset = offset & ~((32'd1 << in_ls[1:0]) - 32'd1);
      in_val_a = region;
      in_val_b = offset;
      in_rd    = 5'(i % 31 + 1);
      compute_expected();
      send_instr();
      collect_result();
    end

    test_name = "jump";
    for (int g = 1; g < 6; g++) begin
      for (int i = 0; i < 8; i++) begin
        clear_instr();
        in_goto  = goto_t'(g[2:0]);
        in_pc    = 32'h8000_0000 | (32'($random(seed)) & 32'h0000_fffc);
        in_val_c = (32'($random(seed)) & 32'h0000_0ffc) + 32'd4;
        if (i[0]) in_val_c = -in_val_c;
        in_val_a = $random(seed);
        if (g >= 4) begin
          // branch condition from val_a xor val_b
          in_alu_funct = alu_xor;
          in_val_b     = i[1] ? in_val_a : 32'($random(seed));
        end else begin
          in_alu_src = 1'b1;
          in_val_b   = 32'd4;
          in_rd      = 5'($random(seed));
        end
        compute_expected();
        send_instr();
        collect_result();
      end
    end

    test_name = "csr";
    for (int i = 0; i < 16; i++) begin
      clear_instr();
      in_csrw      = 2'(i % 4);
      in_val_a     = $random(seed);
      in_val_b     = $random(seed);
      in_val_c     = $random(seed);
      in_alu_funct = alu_funct_t'(3'($random(seed)));
      in_rd        = 5'($random(seed));
      compute_expected();
      send_instr();
      collect_result();
    end

    test_name = "backpressure";
    clear_instr();
    in_goto    = goto_jal;
    in_val_c   = 32'h40;
    in_alu_src = 1'b1;
    in_val_b   = 32'd4;
    in_rd      = 5'd7;
    compute_expected();
    send_instr();
    wait_hold();
    // next instruction waits at the input
    clear_instr();
    in_val_a  = $random(seed);
    in_val_b  = $random(seed);
    in_alu_sw = 1'b1;
    in_rd     = 5'd9;
    in_valid  = 1'b1;
    repeat (6) begin
      @(negedge clock);
      check_value("in_ready", 0, in_ready);
      check_outputs();
      @(posedge clock);
      #2;
    end
    out_ready = 1'b1;
    @(negedge clock);
    check_value("in_ready", 1, in_ready);
    check_outputs();
    @(posedge clock);
    #2;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    compute_expected();
    collect_result();

    test_name = "reset";
    clear_instr();
    in_goto  = goto_jal;
    in_val_c = 32'h100;
    compute_expected();
    send_instr();
    wait_hold();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    check_value("out_valid", 0, out_valid);
    check_value("jump_flush", 0, jump_flush);
    check_value("in_ready", 1, in_ready);
    @(posedge clock);
    #2;

    if (dut_i.props_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim/exu_properties.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_properties (
  input logic                        clock,
  input logic                        reset,
  input logic                        in_ready,
  input logic                        out_ready,
  input logic                        out_valid,
  input logic                        out_gpr_wen,
  input logic [4:0]                  out_gpr_waddr,
  input logic [`EXU_XLEN-1:0]        out_gpr_wdata,
  input logic                        out_csr_wen,
  input logic [`EXU_CSR_AW-1:0]      out_csr_waddr,
  input logic [`EXU_XLEN-1:0]        out_csr_wdata,
  input logic                        jump_flush,
  input logic [`EXU_XLEN-1:0]        jump_dnpc,
  input logic [4:0]                  fwd_rd,
  input logic [`EXU_XLEN-1:0]        fwd_gpr_wdata,
  input logic [`EXU_CSR_AW-1:0]      fwd_csr_waddr,
  input logic                        ar_valid,
  input logic                        ar_ready,
  input logic [`EXU_XLEN-1:0]        ar_addr,
  input logic                        r_valid,
  input logic                        r_ready,
  input logic [`EXU_BUS_WIDTH-1:0]   r_data,
  input logic                        aw_valid,
  input logic                        aw_ready,
  input logic [`EXU_XLEN-1:0]        aw_addr,
  input logic                        w_valid,
  input logic                        w_ready,
  input logic [`EXU_BUS_WIDTH-1:0]   w_data,
  input logic [`EXU_BUS_WIDTH/8-1:0] w_strb,
  input logic                        b_valid,
  input logic                        b_ready
);

  int fail_count = 0;

  logic [4*`EXU_XLEN+2*`EXU_CSR_AW+12:0] out_bundle;
  logic                                  mem_busy;

  assign out_bundle = {out_gpr_wen, out_gpr_waddr, out_gpr_wdata, out_csr_wen,
                       out_csr_waddr, out_csr_wdata, jump_flush, jump_dnpc,
                       fwd_rd, fwd_gpr_wdata, fwd_csr_waddr};
  assign mem_busy = ar_valid | r_ready | aw_valid | w_valid | b_ready;

  // writeback frozen while stalled
  assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_bundle))
  else begin
    fail_count++;
    $error("writeback outputs changed while out_ready was low");
  end

  assert property (@(posedge clock) disable iff (reset) jump_flush |-> out_valid)
  else begin
    fail_count++;
    $error("jump_flush high outside of hold");
  end

  // quiet state right after reset
  assert property (@(posedge clock)
    reset |=> !out_valid && !jump_flush && fwd_rd == '0 && fwd_gpr_wdata == '0 &&
              fwd_csr_waddr == '0 && !ar_valid && !aw_valid && !w_valid &&
              !r_ready && !b_ready)
  else begin
    fail_count++;
    $error("outputs not cleared after reset");
  end

  assert property (@(posedge clock) disable iff (reset) mem_busy |-> !in_ready)
  else begin
    fail_count++;
    $error("in_ready high during a memory access");
  end

  // each channel holds valid and payload until ready
  assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
  else begin
    fail_count++;
    $error("read address dropped before ar_ready");
  end

  assert property (@(posedge clock) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r_data))
  else begin
    fail_count++;
    $error("read data dropped before r_ready");
  end

  assert property (@(posedge clock) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
  else begin
    fail_count++;
    $error("write address dropped before aw_ready");
  end

  assert property (@(posedge clock) disable iff (reset)
    w_valid && !w_ready |=> w_valid && $stable({w_data, w_strb}))
  else begin
    fail_count++;
    $error("write data dropped before w_ready");
  end

  assert property (@(posedge clock) disable iff (reset)
    b_valid && !b_ready |=> b_valid)
  else begin
    fail_count++;
    $error("write response dropped before b_ready");
  end

endmodule

bind exu_top exu_properties props_i (.*);

// File: src/exu_top.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`EXU_XLEN-1:0]   in_pc,
  input  logic [`EXU_XLEN-1:0]   in_val_a,
  input  logic [`EXU_XLEN-1:0]   in_val_b,
  input  logic [`EXU_XLEN-1:0]   in_val_c,
  input  logic                   in_alu_src,
  input  exu_pkg::alu_funct_t    in_alu_funct,
  input  logic                   in_alu_sw,
  input  logic [4:0]             in_rd,
  input  logic                   in_rd_src,
  input  logic [3:0]             in_ls,
  input  exu_pkg::goto_t         in_goto,
  input  logic [1:0]             in_csrw,
  input  logic                   out_ready,
  output logic                   out_valid,
  output logic                   out_gpr_wen,
  output logic [4:0]             out_gpr_waddr,
  output logic [`EXU_XLEN-1:0]   out_gpr_wdata,
  output logic                   out_csr_wen,
  output logic [`EXU_CSR_AW-1:0] out_csr_waddr,
  output logic [`EXU_XLEN-1:0]   out_csr_wdata,
  output logic                   jump_flush,
  output logic [`EXU_XLEN-1:0]   jump_dnpc,
  output logic [4:0]             fwd_rd,
  output logic [`EXU_XLEN-1:0]   fwd_gpr_wdata,
  output logic [`EXU_CSR_AW-1:0] fwd_csr_waddr
);

  // memory channels between the stage and the local ram
  logic                        ar_valid;
  logic                        ar_ready;
  logic [`EXU_XLEN-1:0]        ar_addr;
  logic                        r_valid;
  logic                        r_ready;
  logic [`EXU_BUS_WIDTH-1:0]   r_data;
  logic                        aw_valid;
  logic                        aw_ready;
  logic [`EXU_XLEN-1:0]        aw_addr;
  logic                        w_valid;
  logic                        w_ready;
  logic [`EXU_BUS_WIDTH-1:0]   w_data;
  logic [`EXU_BUS_WIDTH/8-1:0] w_strb;
  logic                        b_valid;
  logic                        b_ready;

  // port names match one to one
  exu exu_i (.*);

  data_ram ram_i (.*);

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module data_ram (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  input  logic [`EXU_XLEN-1:0]        ar_addr,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [`EXU_BUS_WIDTH-1:0]   r_data,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  logic [`EXU_XLEN-1:0]        aw_addr,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  logic [`EXU_BUS_WIDTH-1:0]   w_data,
  input  logic [`EXU_BUS_WIDTH/8-1:0] w_strb,
  output logic                        b_valid,
  input  logic                        b_ready
);

  localparam int idx_w = $clog2(`EXU_RAM_WORDS);

  typedef enum logic [1:0] {
    ram_idle,
    ram_read_resp,
    ram_write_data,
    ram_write_resp
  } ram_state_t;

  ram_state_t              state;
  logic [idx_w-1:0]        waddr;
  logic [`EXU_BUS_WIDTH-1:0] mem [`EXU_RAM_WORDS];

  initial begin
    for (int i = 0; i < `EXU_RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // reads win when both arrive together
  assign ar_ready = (state == ram_idle);
  assign aw_ready = (state == ram_idle) & ~ar_valid;
  assign w_ready  = (state == ram_write_data);
  assign r_valid  = (state == ram_read_resp);
  assign b_valid  = (state == ram_write_resp);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ram_idle;
    end else begin
      case (state)
        ram_idle: begin
          if (ar_valid) begin
            state <= ram_read_resp;
          end else if (aw_valid) begin
            state <= ram_write_data;
          end
        end
        ram_read_resp:  if (r_ready) state <= ram_idle;
        ram_write_data: if (w_valid) state <= ram_write_resp;
        ram_write_resp: if (b_ready) state <= ram_idle;
        default:        state <= ram_idle;
      endcase
    end
  end

  // word index from the bits above the byte offset
  always_ff @(posedge clock) begin
    if (ar_valid & ar_ready) begin
      r_data <= mem[ar_addr[idx_w+2:3]];
    end
    if (aw_valid & aw_ready) begin
      waddr <= aw_addr[idx_w+2:3];
    end
    if (w_valid & w_ready) begin
      for (int b = 0; b < `EXU_BUS_WIDTH/8; b++) begin
        if (w_strb[b]) mem[waddr][b*8 +: 8] <= w_data[b*8 +: 8];
      end
    end
  end

endmodule

// File: src/exu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  logic [`EXU_XLEN-1:0]        in_pc,
  input  logic [`EXU_XLEN-1:0]        in_val_a,
  input  logic [`EXU_XLEN-1:0]        in_val_b,
  input  logic [`EXU_XLEN-1:0]        in_val_c,
  input  logic                        in_alu_src,
  input  exu_pkg::alu_funct_t         in_alu_funct,
  input  logic                        in_alu_sw,
  input  logic [4:0]                  in_rd,
  input  logic                        in_rd_src,
  input  logic [3:0]                  in_ls,
  input  exu_pkg::goto_t              in_goto,
  input  logic [1:0]                  in_csrw,
  input  logic                        out_ready,
  output logic                        out_valid,
  output logic                        out_gpr_wen,
  output logic [4:0]                  out_gpr_waddr,
  output logic [`EXU_XLEN-1:0]        out_gpr_wdata,
  output logic                        out_csr_wen,
  output logic [`EXU_CSR_AW-1:0]      out_csr_waddr,
  output logic [`EXU_XLEN-1:0]        out_csr_wdata,
  output logic                        jump_flush,
  output logic [`EXU_XLEN-1:0]        jump_dnpc,
  output logic [4:0]                  fwd_rd,
  output logic [`EXU_XLEN-1:0]        fwd_gpr_wdata,
  output logic [`EXU_CSR_AW-1:0]      fwd_csr_waddr,
  output logic                        ar_valid,
  input  logic                        ar_ready,
  output logic [`EXU_XLEN-1:0]        ar_addr,
  input  logic                        r_valid,
  output logic                        r_ready,
  input  logic [`EXU_BUS_WIDTH-1:0]   r_data,
  output logic                        aw_valid,
  input  logic                        aw_ready,
  output logic [`EXU_XLEN-1:0]        aw_addr,
  output logic                        w_valid,
  input  logic                        w_ready,
  output logic [`EXU_BUS_WIDTH-1:0]   w_data,
  output logic [`EXU_BUS_WIDTH/8-1:0] w_strb,
  input  logic                        b_valid,
  output logic                        b_ready
);
  import exu_pkg::*;

  exu_state_t state;
  exu_state_t state_next;
  exu_state_t entry_state;
  logic       accept;
  logic       st_idle;

  logic [`EXU_XLEN-1:0] pc;
  logic [`EXU_XLEN-1:0] val_a;
  logic [`EXU_XLEN-1:0] val_b;
  logic [`EXU_XLEN-1:0] val_c;
  logic                 alu_src;
  alu_funct_t           alu_funct;
  logic                 alu_sw;
  logic [4:0]           rd;
  logic                 rd_src;
  logic [3:0]           ls;
  goto_t                goto;
  logic [1:0]           csrw;
  logic [`EXU_XLEN-1:0] load_val;

  logic [`EXU_XLEN-1:0] alu_a;
  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] load_value;

  assign st_idle   = (state == s_idle);
  assign out_valid = (state == s_hold);
  assign in_ready  = st_idle | (out_valid & out_ready);
  assign accept    = in_valid & in_ready;

  always_comb begin
    if (in_ls == 4'd0) begin
      entry_state = s_hold;
    end else if (in_ls[3]) begin
      entry_state = s_load_req;
    end else begin
      entry_state = s_store_req;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_idle: begin
        if (accept) state_next = entry_state;
      end
      s_hold: begin
        if (out_ready) state_next = accept ? entry_state : s_idle;
      end
      s_load_req: begin
        if (ar_ready) state_next = s_load_resp;
      end
      s_load_resp: begin
        if (r_valid) state_next = s_hold;
      end
      // address and data may be taken in either order
      s_store_req: begin
        if (aw_ready & w_ready) begin
          state_next = s_store_resp;
        end else if (aw_ready) begin
          state_next = s_store_data;
        end else if (w_ready) begin
          state_next = s_store_addr;
        end
      end
      s_store_addr: begin
        if (aw_ready) state_next = s_store_resp;
      end
      s_store_data: begin
        if (w_ready) state_next = s_store_resp;
      end
      s_store_resp: begin
        if (b_valid) state_next = s_hold;
      end
      default: state_next = s_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // instruction register
  always_ff @(posedge clock) begin
    if (accept) begin
      pc        <= in_pc;
      val_a     <= in_val_a;
      val_b     <= in_val_b;
      val_c     <= in_val_c;
      alu_src   <= in_alu_src;
      alu_funct <= in_alu_funct;
      alu_sw    <= in_alu_sw;
      rd        <= in_rd;
      rd_src    <= in_rd_src;
      ls        <= in_ls;
      goto      <= in_goto;
      csrw      <= in_csrw;
    end
    if (r_valid & r_ready) begin
      load_val <= load_value;
    end
  end

  assign alu_a = alu_src ? pc : val_a;

  exu_alu alu_i (
    .alu_a  (alu_a),
    .alu_b  (val_b),
    .funct  (alu_funct),
    .sw     (alu_sw),
    .result (alu_result)
  );

  exu_mem_align align_i (
    .addr_low    (alu_result[2:0]),
    .ls          (ls),
    .store_value (val_c),
    .r_data      (r_data),
    .w_data      (w_data),
    .w_strb      (w_strb),
    .load_value  (load_value)
  );

  exu_branch branch_i (
    .goto       (goto),
    .pc         (pc),
    .val_a      (val_a),
    .val_c      (val_c),
    .alu_result (alu_result),
    .holding    (out_valid),
    .jump_flush (jump_flush),
    .jump_dnpc  (jump_dnpc)
  );

  // memory channels
  assign ar_valid = (state == s_load_req);
  assign ar_addr  = alu_result;
  assign r_ready  = (state == s_load_resp);
  assign aw_valid = (state == s_store_req) | (state == s_store_addr);
  assign aw_addr  = alu_result;
  assign w_valid  = (state == s_store_req) | (state == s_store_data);
  assign b_ready  = (state == s_store_resp);

  // writeback
  assign out_gpr_wen   = |rd;
  assign out_gpr_waddr = rd;
  assign out_gpr_wdata = ls[3] ? load_val : (rd_src ? val_a : alu_result);

  // ebreak shows up as a write to csr 0
  assign out_csr_wen   = |csrw;
  assign out_csr_waddr = (&csrw) ? '0 : val_c[`EXU_CSR_AW-1:0];
  assign out_csr_wdata = csrw[1] ? val_b : alu_result;

  assign fwd_rd        = st_idle ? '0 : rd;
  assign fwd_gpr_wdata = st_idle ? '0 : out_gpr_wdata;
  assign fwd_csr_waddr = (st_idle | ~out_csr_wen) ? '0 : out_csr_waddr;

endmodule

// File: src/exu_branch.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_branch (
  input  exu_pkg::goto_t       goto,
  input  logic [`EXU_XLEN-1:0] pc,
  input  logic [`EXU_XLEN-1:0] val_a,
  input  logic [`EXU_XLEN-1:0] val_c,
  input  logic [`EXU_XLEN-1:0] alu_result,
  input  logic                 holding,
  output logic                 jump_flush,
  output logic [`EXU_XLEN-1:0] jump_dnpc
);
  import exu_pkg::*;

  logic                 taken;
  logic                 predicted;
  logic                 is_branch;
  logic [`EXU_XLEN-1:0] base;
  logic [`EXU_XLEN-1:0] offset;
  logic [`EXU_XLEN-1:0] target;

  always_comb begin
    case (goto)
      goto_none:      taken = 1'b0;
      goto_branch_nz: taken = |alu_result;
      goto_branch_z:  taken = ~|alu_result;
      default:        taken = 1'b1;
    endcase
  end

  assign base   = (goto == goto_jalr || goto == goto_jump_reg) ? val_a : pc;
  assign offset = (goto == goto_jump_reg) ? '0 : val_c;
  assign target = base + (taken ? offset : `EXU_XLEN'd4);

  assign jump_dnpc = {target[`EXU_XLEN-1:1], 1'b0};

  // backward taken, forward not taken, only for branches
  assign is_branch  = (goto == goto_branch_nz) || (goto == goto_branch_z);
  assign predicted  = is_branch & val_c[`EXU_XLEN-1];
  assign jump_flush = holding & (taken ^ predicted);

endmodule

// File: src/exu_mem_align.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_mem_align (
  input  logic [2:0]                   addr_low,
  input  logic [3:0]                   ls,
  input  logic [`EXU_XLEN-1:0]         store_value,
  input  logic [`EXU_BUS_WIDTH-1:0]    r_data,
  output logic [`EXU_BUS_WIDTH-1:0]    w_data,
  output logic [`EXU_BUS_WIDTH/8-1:0]  w_strb,
  output logic [`EXU_XLEN-1:0]         load_value
);

  logic [3:0]                size_mask;
  logic [`EXU_BUS_WIDTH-1:0] lane_data;
  logic [5:0]                bit_offset;

  assign bit_offset = {addr_low, 3'b000};

  // store side
  always_comb begin
    case (ls[1:0])
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      2'b10:   size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  assign w_data = {{(`EXU_BUS_WIDTH-`EXU_XLEN){1'b0}}, store_value} << bit_offset;
  assign w_strb = {{(`EXU_BUS_WIDTH/8-4){1'b0}}, size_mask} << addr_low;

  // load side, addressed byte moved down to lane 0
  assign lane_data = r_data >> bit_offset;

  always_comb begin
    case (ls[1:0])
      2'b00:   load_value = {{24{lane_data[7] & ls[2]}}, lane_data[7:0]};
      2'b01:   load_value = {{16{lane_data[15] & ls[2]}}, lane_data[15:0]};
      default: load_value = lane_data[31:0];
    endcase
  end

endmodule

// File: src/exu_alu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] alu_a,
  input  logic [`EXU_XLEN-1:0] alu_b,
  input  exu_pkg::alu_funct_t  funct,
  input  logic                 sw,
  output logic [`EXU_XLEN-1:0] result
);
  import exu_pkg::*;

  logic [4:0]                 shamt;
  logic signed [`EXU_XLEN-1:0] sra_val;

  assign shamt = alu_b[4:0];
  // kept apart so the shift stays arithmetic
  assign sra_val = $signed(alu_a) >>> shamt;

  always_comb begin
    case (funct)
      alu_add:  result = sw ? alu_a - alu_b : alu_a + alu_b;
      alu_sll:  result = alu_a << shamt;
      alu_slt:  result = {{(`EXU_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      alu_sltu: result = {{(`EXU_XLEN-1){1'b0}}, alu_a < alu_b};
      alu_xor:  result = alu_a ^ alu_b;
      alu_srl: begin
        if (sw) begin
          result = sra_val;
        end else begin
          result = alu_a >> shamt;
        end
      end
      alu_or:   result = alu_a | alu_b;
      alu_and:  result = alu_a & alu_b;
      default:  result = alu_a + alu_b;
    endcase
  end

endmodule

// File: src/exu_pkg.sv
package exu_pkg;

  // execute stage states, stores split address and data
  typedef enum logic [2:0] {
    s_idle,
    s_hold,
    s_load_req,
    s_load_resp,
    s_store_req,
    s_store_addr,
    s_store_data,
    s_store_resp
  } exu_state_t;

  // funct3 order; alu_sw turns add into sub and srl into sra
  typedef enum logic [2:0] {
    alu_add,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_or,
    alu_and
  } alu_funct_t;

  // jump kinds
  typedef enum logic [2:0] {
    goto_none,
    goto_jal,
    goto_jalr,
    goto_jump_reg,
    goto_branch_nz,
    goto_branch_z
  } goto_t;

  // ls code, 4 bits, zero means no memory access
  //   bit 3    load
  //   bit 2    sign extend on load, always set on store
  //   bits 1:0 size: byte, half, word
  //
  // csrw code, 2 bits
  //   0  none
  //   1  alu result to csr val_c[11:0]
  //   2  val_b to csr val_c[11:0]
  //   3  ebreak marker, val_b to csr 0

endpackage

// File: src/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// register and address width
`define EXU_XLEN 32

// memory data width, one strobe bit per byte
`define EXU_BUS_WIDTH 64

// data_ram depth in bus words
`define EXU_RAM_WORDS 256

// csr address width
`define EXU_CSR_AW 12

`endif
